// File: pci_bus_pkg.sv
/* PCI bus types */

package pci_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  be_t;	// active low, one per byte lane
	typedef logic [15:0] count_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus commands, standard PCI encodings on c/be
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		io_read   = 4'b0010,
		io_write  = 4'b0011,
		mem_read  = 4'b0110,
		mem_write = 4'b0111,
		cfg_read  = 4'b1010,
		cfg_write = 4'b1011
	} cmd_t;

endpackage

// File: pci_agent_pkg.sv
/* PCI agent status and states */

package pci_agent_pkg;

	typedef enum logic [1:0] {
		st_ok           = 2'd0,
		st_retry_abort  = 2'd1,
		st_master_abort = 2'd2
	} status_t;

	// how a data phase ended
	typedef enum logic [1:0] {
		term_none  = 2'd0,
		term_xfer  = 2'd1,
		term_retry = 2'd2,
		term_abort = 2'd3
	} term_t;

	typedef enum logic [2:0] {
		init_idle,
		init_request,
		init_address,
		init_data,
		init_backoff,
		init_report
	} init_state_t;

	typedef enum logic [1:0] {
		tgt_idle,
		tgt_claim,
		tgt_turnaround
	} tgt_state_t;

endpackage

// File: pci_init_if.sv
/* Initiator to arbiter link */
`timescale 1ns/100ps

interface pci_init_if import pci_bus_pkg::*; ();

	logic       req_n;
	logic       gnt_n;
	logic       frame_n;
	logic       irdy_n;
	data_t      ad_out;
	logic [3:0] cbe;	// command in address phase, byte enables in data phase
	logic       trdy_n;
	logic       devsel_n;
	logic       stop_n;
	data_t      ad_in;	// read data returned from the target

	modport master (
		output req_n, frame_n, irdy_n, ad_out, cbe,
		input  gnt_n, trdy_n, devsel_n, stop_n, ad_in
	);

	modport arbiter (
		input  req_n, frame_n, irdy_n, ad_out, cbe,
		output gnt_n, trdy_n, devsel_n, stop_n, ad_in
	);

endinterface

// File: pci_bus_if.sv
/* Shared PCI bus */
`timescale 1ns/100ps

interface pci_bus_if import pci_bus_pkg::*; ();

	logic       frame_n;
	logic       irdy_n;
	data_t      ad;
	logic [3:0] cbe;
	data_t      rd_data;	// target read path, replaces the turned-around ad
	logic       devsel_n;
	logic       trdy_n;
	logic       stop_n;

	modport arbiter (
		output frame_n, irdy_n, ad, cbe,
		input  rd_data, devsel_n, trdy_n, stop_n
	);

	modport target (
		input  frame_n, irdy_n, ad, cbe,
		output rd_data, devsel_n, trdy_n, stop_n
	);

	modport monitor (
		input frame_n, irdy_n, ad, cbe, rd_data, devsel_n, trdy_n, stop_n
	);

endinterface

// File: pci_arbiter.sv
/* Round-robin bus arbiter */
`timescale 1ns/100ps

module pci_arbiter #(
	parameter int PARK = 0
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       bus_idle,
	pci_init_if.arbiter m0,
	pci_init_if.arbiter m1,
	pci_bus_if.arbiter  bus
);

	logic owner_vld;	// some initiator holds the grant
	logic owner;
	logic last_gnt;
	logic req0;
	logic req1;
	logic can_switch;
	logic nxt_owner;

	assign req0       = !m0.req_n;
	assign req1       = !m1.req_n;
	assign can_switch = bus_idle && bus.frame_n && bus.irdy_n;

	// the owner keeps the grant while it still requests
	always_comb
	begin
		if (owner_vld && (owner ? req1 : req0))
			nxt_owner = owner;
		else if (req0 && req1)
			nxt_owner = !last_gnt;
		else if (req0)
			nxt_owner = 1'b0;
		else if (req1)
			nxt_owner = 1'b1;
		else
			nxt_owner = PARK[0];	// park
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			owner_vld <= 1'b0;
			owner     <= 1'b0;
			last_gnt  <= 1'b1;
		end
		else if (can_switch)
		begin
			owner_vld <= 1'b1;
			owner     <= nxt_owner;
			if (req0 || req1)
				last_gnt <= nxt_owner;
		end
	end

	// grant is only shown while the bus is idle
	assign m0.gnt_n = !(owner_vld && !owner && bus_idle);
	assign m1.gnt_n = !(owner_vld && owner && bus_idle);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus multiplexer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		bus.frame_n = 1'b1;
		bus.irdy_n  = 1'b1;
		bus.ad      = '0;
		bus.cbe     = '1;
		if (owner_vld && owner)
		begin
			bus.frame_n = m1.frame_n;
			bus.irdy_n  = m1.irdy_n;
			bus.ad      = m1.ad_out;
			bus.cbe     = m1.cbe;
		end
		else if (owner_vld)
		begin
			bus.frame_n = m0.frame_n;
			bus.irdy_n  = m0.irdy_n;
			bus.ad      = m0.ad_out;
			bus.cbe     = m0.cbe;
		end
	end

	assign m0.trdy_n   = bus.trdy_n;
	assign m0.devsel_n = bus.devsel_n;
	assign m0.stop_n   = bus.stop_n;
	assign m0.ad_in    = bus.rd_data;
	assign m1.trdy_n   = bus.trdy_n;
	assign m1.devsel_n = bus.devsel_n;
	assign m1.stop_n   = bus.stop_n;
	assign m1.ad_in    = bus.rd_data;

endmodule

// File: pci_initiator.sv
/* PCI bus initiator */
`timescale 1ns/100ps

module pci_initiator import pci_bus_pkg::*, pci_agent_pkg::*; #(
	parameter int RETRY_LIMIT = 4,
	parameter int ABORT_WAIT  = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  cmd_t       cmd,
	input  addr_t      addr,
	input  data_t      wdata,
	input  be_t        be,
	output logic       done,
	output data_t      rdata,
	output status_t    status,
	pci_init_if.master port
);

	localparam int RW = $clog2(RETRY_LIMIT + 1);
	localparam int WW = $clog2(ABORT_WAIT + 1);

	init_state_t   state;
	term_t         term;
	cmd_t          cmd_q;
	addr_t         addr_q;
	data_t         wdata_q;
	be_t           be_q;
	logic [RW-1:0] retry_cnt;
	logic [WW-1:0] wait_cnt;
	logic          bo_cnt;	// backoff cycle
	logic          last_try;

	assign last_try = retry_cnt == RW'(RETRY_LIMIT - 1);

	always_comb
	begin
		term = term_none;
		if (state == init_data)
		begin
			if (!port.trdy_n)
				term = term_xfer;
			else if (!port.stop_n)
				term = term_retry;
			else if (port.devsel_n && wait_cnt == WW'(ABORT_WAIT - 1))
				term = term_abort;	// nobody claimed it
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transaction FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state     <= init_idle;
			retry_cnt <= '0;
			wait_cnt  <= '0;
			bo_cnt    <= 1'b0;
		end
		else
		begin
			case (state)
				init_idle:
					if (start)
					begin
						state     <= init_request;
						retry_cnt <= '0;
					end
				init_request:
					if (!port.gnt_n)
						state <= init_address;
				init_address:
				begin
					state    <= init_data;
					wait_cnt <= '0;
				end
				init_data:
					case (term)
						term_xfer, term_abort:
							state <= init_report;
						term_retry:
							if (last_try)
								state <= init_report;
							else
							begin
								state     <= init_backoff;
								retry_cnt <= retry_cnt + 1'b1;
								bo_cnt    <= 1'b0;
							end
						default:
							wait_cnt <= wait_cnt + 1'b1;
					endcase
				init_backoff:
					if (bo_cnt)
						state <= init_request;
					else
						bo_cnt <= 1'b1;
				default:
					state <= init_idle;	// report lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == init_idle && start)
		begin
			cmd_q   <= cmd;
			addr_q  <= addr;
			wdata_q <= wdata;
			be_q    <= be;
		end
		if (term == term_xfer)
		begin
			status <= st_ok;
			if (!cmd_q[0])
				rdata <= port.ad_in;	// reads have bit 0 clear
		end
		else if (term == term_abort)
			status <= st_master_abort;
		else if (term == term_retry && last_try)
			status <= st_retry_abort;
	end

	assign port.req_n   = !(state == init_request || state == init_address ||
				state == init_data);
	assign port.frame_n = state != init_address;
	assign port.irdy_n  = state != init_data;
	assign port.ad_out  = (state == init_address) ? addr_q : wdata_q;
	assign port.cbe     = (state == init_address) ? cmd_q : be_q;
	assign done         = state == init_report;

endmodule

// File: pci_target.sv
/* Memory and I/O target */
`timescale 1ns/100ps

module pci_target import pci_bus_pkg::*, pci_agent_pkg::*; #(
	parameter addr_t MEM_BASE  = 32'h00010000,
	parameter int    MEM_WORDS = 256,
	parameter addr_t IO_BASE   = 32'h00000F00
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      busy,
	pci_bus_if.target bus
);

	localparam int    IW       = $clog2(MEM_WORDS);
	localparam addr_t MEM_SPAN = addr_t'(MEM_WORDS * 4);
	localparam addr_t IO_SPAN  = addr_t'(16);	// four word registers

	tgt_state_t    state;
	cmd_t          cmd_in;
	cmd_t          cmd_q;
	addr_t         mem_off;
	addr_t         io_off;
	logic          mem_hit;
	logic          io_hit;
	logic          is_io;
	logic          is_write;
	logic          wr_en;
	logic [IW-1:0] mem_idx;
	logic [1:0]    io_idx;
	data_t         mem [MEM_WORDS];
	data_t         io_regs [4];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign cmd_in   = cmd_t'(bus.cbe);
	assign mem_off  = bus.ad - MEM_BASE;	// wraps high below the base
	assign io_off   = bus.ad - IO_BASE;
	assign mem_hit  = (cmd_in == mem_read || cmd_in == mem_write) && mem_off < MEM_SPAN;
	assign io_hit   = (cmd_in == io_read || cmd_in == io_write) && io_off < IO_SPAN;
	assign is_io    = cmd_q == io_read || cmd_q == io_write;
	assign is_write = cmd_q == io_write || cmd_q == mem_write;
	assign wr_en    = state == tgt_claim && is_write && !bus.irdy_n && !bus.trdy_n;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state        <= tgt_idle;
			bus.devsel_n <= 1'b1;
			bus.trdy_n   <= 1'b1;
			bus.stop_n   <= 1'b1;
		end
		else
		begin
			case (state)
				tgt_idle:
					if (!bus.frame_n && (mem_hit || io_hit))
					begin
						state        <= tgt_claim;
						bus.devsel_n <= 1'b0;
						if (busy)
							bus.stop_n <= 1'b0;	// retry
						else
							bus.trdy_n <= 1'b0;
					end
				tgt_claim:
				begin
					state        <= tgt_turnaround;
					bus.devsel_n <= 1'b1;
					bus.trdy_n   <= 1'b1;
					bus.stop_n   <= 1'b1;
				end
				default:
					state <= tgt_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == tgt_idle && !bus.frame_n)
		begin
			cmd_q       <= cmd_in;
			mem_idx     <= mem_off[IW+1:2];
			io_idx      <= io_off[3:2];
			bus.rd_data <= io_hit ? io_regs[io_off[3:2]] : mem[mem_off[IW+1:2]];
		end
		if (wr_en && !is_io)
			for (int i = 0; i < 4; i++)
				if (!bus.cbe[i])
					mem[mem_idx][8*i +: 8] <= bus.ad[8*i +: 8];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			for (int r = 0; r < 4; r++)
				io_regs[r] <= '0;
		else if (wr_en && is_io)
			for (int i = 0; i < 4; i++)
				if (!bus.cbe[i])
					io_regs[io_idx][8*i +: 8] <= bus.ad[8*i +: 8];
	end

endmodule

// File: pci_monitor.sv
/* Bus monitor */
`timescale 1ns/100ps

module pci_monitor import pci_bus_pkg::*, pci_agent_pkg::*; #(
	parameter int ABORT_WAIT = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	pci_bus_if.monitor bus,
	output logic       bus_idle,
	output count_t     xfer_count,
	output count_t     retry_count,
	output count_t     abort_count
);

	localparam int WW = $clog2(ABORT_WAIT + 1);

	logic [WW-1:0] wait_cnt;	// data phase cycles without devsel
	term_t         term;

	always_comb
	begin
		term = term_none;
		if (!bus.irdy_n)
		begin
			if (!bus.trdy_n)
				term = term_xfer;
			else if (!bus.stop_n)
				term = term_retry;
			else if (bus.devsel_n && wait_cnt == WW'(ABORT_WAIT - 1))
				term = term_abort;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bus_idle    <= 1'b0;
			wait_cnt    <= '0;
			xfer_count  <= '0;
			retry_count <= '0;
			abort_count <= '0;
		end
		else
		begin
			bus_idle <= bus.frame_n && bus.irdy_n;
			if (!bus.frame_n)
				wait_cnt <= '0;
			else if (!bus.irdy_n && term == term_none)
				wait_cnt <= wait_cnt + 1'b1;
			case (term)
				term_xfer:  xfer_count  <= xfer_count + 1'b1;
				term_retry: retry_count <= retry_count + 1'b1;
				term_abort: abort_count <= abort_count + 1'b1;
				default:    ;
			endcase
		end
	end

endmodule

// File: pci_subsys.sv
/* PCI bus subsystem top level */
`timescale 1ns/100ps

module pci_subsys import pci_bus_pkg::*, pci_agent_pkg::*; #(
	parameter addr_t MEM_BASE    = 32'h00010000,
	parameter int    MEM_WORDS   = 256,
	parameter addr_t IO_BASE     = 32'h00000F00,
	parameter int    RETRY_LIMIT = 4,
	parameter int    ABORT_WAIT  = 4,
	parameter int    PARK        = 0
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    target_busy,
	input  logic    m0_start,
	input  cmd_t    m0_cmd,
	input  addr_t   m0_addr,
	input  data_t   m0_wdata,
	input  be_t     m0_be,
	output logic    m0_done,
	output data_t   m0_rdata,
	output status_t m0_status,
	input  logic    m1_start,
	input  cmd_t    m1_cmd,
	input  addr_t   m1_addr,
	input  data_t   m1_wdata,
	input  be_t     m1_be,
	output logic    m1_done,
	output data_t   m1_rdata,
	output status_t m1_status,
	output count_t  xfer_count,
	output count_t  retry_count,
	output count_t  abort_count
);

	logic bus_idle;

	pci_init_if m0_if ();
	pci_init_if m1_if ();
	pci_bus_if  bus_if ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// initiators
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	pci_initiator #(.RETRY_LIMIT(RETRY_LIMIT), .ABORT_WAIT(ABORT_WAIT)) u_init0 (
		.clk(clk), .rst_n(rst_n), .start(m0_start), .cmd(m0_cmd), .addr(m0_addr),
		.wdata(m0_wdata), .be(m0_be), .done(m0_done), .rdata(m0_rdata),
		.status(m0_status), .port(m0_if.master)
	);

	pci_initiator #(.RETRY_LIMIT(RETRY_LIMIT), .ABORT_WAIT(ABORT_WAIT)) u_init1 (
		.clk(clk), .rst_n(rst_n), .start(m1_start), .cmd(m1_cmd), .addr(m1_addr),
		.wdata(m1_wdata), .be(m1_be), .done(m1_done), .rdata(m1_rdata),
		.status(m1_status), .port(m1_if.master)
	);

	pci_arbiter #(.PARK(PARK)) u_arb (
		.clk(clk), .rst_n(rst_n), .bus_idle(bus_idle),
		.m0(m0_if.arbiter), .m1(m1_if.arbiter), .bus(bus_if.arbiter)
	);

	pci_target #(.MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS), .IO_BASE(IO_BASE)) u_tgt (
		.clk(clk), .rst_n(rst_n), .busy(target_busy), .bus(bus_if.target)
	);

	pci_monitor #(.ABORT_WAIT(ABORT_WAIT)) u_mon (
		.clk(clk), .rst_n(rst_n), .bus(bus_if.monitor), .bus_idle(bus_idle),
		.xfer_count(xfer_count), .retry_count(retry_count), .abort_count(abort_count)
	);

endmodule

// File: tb_clk_gen.sv
/* Testbench clock */
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// File: tb_pci_subsys.sv
/* PCI subsystem testbench */
`timescale 1ns/100ps

module tb_pci_subsys import pci_bus_pkg::*, pci_agent_pkg::*; ();

	localparam addr_t MEM_BASE    = 32'h00010000;
	localparam int    MEM_WORDS   = 256;
	localparam addr_t IO_BASE     = 32'h00000F00;
	localparam int    RETRY_LIMIT = 4;
	localparam int    IW          = $clog2(MEM_WORDS);

	typedef struct {
		logic    who;	// initiator index
		cmd_t    cmd;
		addr_t   addr;
		data_t   wdata;
		be_t     be;
		logic    busy;
		status_t exp;
		logic    pair;	// starts in the same cycle as the next entry
	} entry_t;

	logic    clk;
	logic    rst_n;
	logic    target_busy;
	logic    m0_start;
	cmd_t    m0_cmd;
	addr_t   m0_addr;
	data_t   m0_wdata;
	be_t     m0_be;
	logic    m0_done;
	data_t   m0_rdata;
	status_t m0_status;
	logic    m1_start;
	cmd_t    m1_cmd;
	addr_t   m1_addr;
	data_t   m1_wdata;
	be_t     m1_be;
	logic    m1_done;
	data_t   m1_rdata;
	status_t m1_status;
	count_t  xfer_count;
	count_t  retry_count;
	count_t  abort_count;

	entry_t  tbl[$];
	data_t   ref_mem [MEM_WORDS];
	data_t   ref_io [4];
	count_t  exp_xfer;
	count_t  exp_retry;
	count_t  exp_abort;
	int      seed = 9148;
	int      cycles = 0;
	int      cycle_limit = 1000;
	int      status_errs = 0;
	int      data_errs = 0;
	int      count_errs = 0;

	tb_clk_gen #(.PERIOD(40)) u_clk (.clk(clk));

	pci_subsys #(
		.MEM_BASE(MEM_BASE), .MEM_WORDS(MEM_WORDS), .IO_BASE(IO_BASE),
		.RETRY_LIMIT(RETRY_LIMIT), .ABORT_WAIT(4), .PARK(0)
	) DUT (
		.clk(clk), .rst_n(rst_n), .target_busy(target_busy),
		.m0_start(m0_start), .m0_cmd(m0_cmd), .m0_addr(m0_addr), .m0_wdata(m0_wdata),
		.m0_be(m0_be), .m0_done(m0_done), .m0_rdata(m0_rdata), .m0_status(m0_status),
		.m1_start(m1_start), .m1_cmd(m1_cmd), .m1_addr(m1_addr), .m1_wdata(m1_wdata),
		.m1_be(m1_be), .m1_done(m1_done), .m1_rdata(m1_rdata), .m1_status(m1_status),
		.xfer_count(xfer_count), .retry_count(retry_count), .abort_count(abort_count)
	);

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic add_entry(input logic who, input cmd_t cmd, input addr_t addr,
		input be_t be, input logic busy, input status_t exp, input logic pair);
		entry_t e;
		e.who   = who;
		e.cmd   = cmd;
		e.addr  = addr;
		e.wdata = $random(seed);
		e.be    = be;
		e.busy  = busy;
		e.exp   = exp;
		e.pair  = pair;
		tbl.push_back(e);
	endtask

	function automatic logic is_io(input cmd_t cmd);
		return cmd == io_read || cmd == io_write;
	endfunction

	function automatic data_t ref_word(input cmd_t cmd, input addr_t addr);
		addr_t off;
		off = addr - MEM_BASE;
		if (is_io(cmd))
			return ref_io[addr[3:2]];
		return ref_mem[off[IW+1:2]];
	endfunction

	// merge the enabled byte lanes into the reference model
	task automatic ref_write(input entry_t e);
		data_t w;
		addr_t off;
		w   = ref_word(e.cmd, e.addr);
		off = e.addr - MEM_BASE;
		for (int i = 0; i < 4; i++)
			if (!e.be[i])
				w[8*i +: 8] = e.wdata[8*i +: 8];
		if (is_io(e.cmd))
			ref_io[e.addr[3:2]] = w;
		else
			ref_mem[off[IW+1:2]] = w;
	endtask

	task automatic drive_entry(input entry_t e);
		if (e.who == 1'b0)
		begin
			m0_start = 1'b1;
			m0_cmd   = e.cmd;
			m0_addr  = e.addr;
			m0_wdata = e.wdata;
			m0_be    = e.be;
		end
		else
		begin
			m1_start = 1'b1;
			m1_cmd   = e.cmd;
			m1_addr  = e.addr;
			m1_wdata = e.wdata;
			m1_be    = e.be;
		end
	endtask

	task automatic check_result(input entry_t e, input status_t got_st, input data_t got_rd,
		input data_t exp_rd, input string name);
		if (got_st !== e.exp)
		begin
			$display("[FAIL] %0t %s_status expected %s got %s", $time, name,
				e.exp.name(), got_st.name());
			status_errs++;
		end
		if (e.exp == st_ok && (e.cmd == mem_read || e.cmd == io_read) && got_rd !== exp_rd)
		begin
			$display("[FAIL] %0t %s_rdata expected %h got %h", $time, name, exp_rd, got_rd);
			data_errs++;
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
			count_errs++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apply one entry, or a pair started in the same cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_group(input int first, input int n);
		logic   seen [2];
		data_t  exp_rd [2];
		int     idx [2];
		entry_t e;
		seen[0] = 1'b1;
		seen[1] = 1'b1;
		@(posedge clk);
		#2;
		for (int k = 0; k < n; k++)
		begin
			e             = tbl[first + k];
			idx[e.who]    = first + k;
			seen[e.who]   = 1'b0;
			exp_rd[e.who] = ref_word(e.cmd, e.addr);
			target_busy   = e.busy;
			drive_entry(e);
		end
		@(posedge clk);
		#2;
		m0_start = 1'b0;
		m1_start = 1'b0;
		while (!seen[0] || !seen[1])
		begin
			@(negedge clk);
			if (m0_done && !seen[0])
			begin
				check_result(tbl[idx[0]], m0_status, m0_rdata, exp_rd[0], "m0");
				seen[0] = 1'b1;
			end
			if (m1_done && !seen[1])
			begin
				check_result(tbl[idx[1]], m1_status, m1_rdata, exp_rd[1], "m1");
				seen[1] = 1'b1;
			end
		end
		for (int k = 0; k < n; k++)
		begin
			e = tbl[first + k];
			case (e.exp)
				st_ok:          exp_xfer = exp_xfer + 16'd1;
				st_retry_abort: exp_retry = exp_retry + count_t'(RETRY_LIMIT);
				default:        exp_abort = exp_abort + 16'd1;
			endcase
			if (e.exp == st_ok && (e.cmd == mem_write || e.cmd == io_write))
				ref_write(e);
		end
		check_count("xfer_count", xfer_count, exp_xfer);
		check_count("retry_count", retry_count, exp_retry);
		check_count("abort_count", abort_count, exp_abort);
	endtask

	initial
	begin
		int i;
		int n_ok;
		rst_n       = 1'b0;
		target_busy = 1'b0;
		m0_start    = 1'b0;
		m0_cmd      = mem_read;
		m0_addr     = '0;
		m0_wdata    = '0;
		m0_be       = '1;
		m1_start    = 1'b0;
		m1_cmd      = mem_read;
		m1_addr     = '0;
		m1_wdata    = '0;
		m1_be       = '1;
		exp_xfer    = '0;
		exp_retry   = '0;
		exp_abort   = '0;
		for (int r = 0; r < 4; r++)
			ref_io[r] = '0;

		// who, command, address, byte enables, busy, expected status, paired
		add_entry(1'b0, mem_write, 32'h00010010, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b0, mem_write, 32'h00010010, 4'b1010, 1'b0, st_ok, 1'b0);
		add_entry(1'b0, mem_read,  32'h00010010, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, io_write,  32'h00000F04, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, io_write,  32'h00000F0C, 4'b0011, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, io_read,   32'h00000F04, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, io_read,   32'h00000F0C, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, io_read,   32'h00000F08, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b0, cfg_read,  32'h00010010, 4'b0000, 1'b0, st_master_abort, 1'b0);
		add_entry(1'b1, mem_write, 32'h00020000, 4'b0000, 1'b0, st_master_abort, 1'b0);
		add_entry(1'b0, io_read,   32'h00000F10, 4'b0000, 1'b0, st_master_abort, 1'b0);
		add_entry(1'b0, mem_write, 32'h00010020, 4'b0000, 1'b1, st_retry_abort, 1'b0);
		add_entry(1'b1, io_write,  32'h00000F00, 4'b0000, 1'b1, st_retry_abort, 1'b0);
		add_entry(1'b0, mem_write, 32'h00010040, 4'b0000, 1'b0, st_ok, 1'b1);
		add_entry(1'b1, mem_read,  32'h00010010, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b0, mem_read,  32'h00010040, 4'b0000, 1'b0, st_ok, 1'b1);
		add_entry(1'b1, io_read,   32'h00000F00, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b0, mem_write, 32'h000103FC, 4'b0000, 1'b0, st_ok, 1'b0);
		add_entry(1'b1, mem_read,  32'h000103FC, 4'b0000, 1'b0, st_ok, 1'b0);
		cycle_limit = 200 * tbl.size();

		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		if (m0_done !== 1'b0)
		begin
			$display("[FAIL] %0t m0_done expected 0 got %b", $time, m0_done);
			status_errs++;
		end
		if (m1_done !== 1'b0)
		begin
			$display("[FAIL] %0t m1_done expected 0 got %b", $time, m1_done);
			status_errs++;
		end
		check_count("xfer_count", xfer_count, 16'd0);
		check_count("retry_count", retry_count, 16'd0);
		check_count("abort_count", abort_count, 16'd0);

		i = 0;
		while (i < tbl.size())
		begin
			if (tbl[i].pair && i + 1 < tbl.size())
			begin
				run_group(i, 2);
				i = i + 2;
			end
			else
			begin
				run_group(i, 1);
				i = i + 1;
			end
		end

		n_ok = 0;
		foreach (tbl[k])
			if (tbl[k].exp == st_ok)
				n_ok++;
		check_count("xfer_count", xfer_count, count_t'(n_ok));

		$display("errors %0d: status %0d, read data %0d, counters %0d",
			status_errs + data_errs + count_errs, status_errs, data_errs, count_errs);
		if (status_errs + data_errs + count_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim.f
pci_bus_pkg.sv
pci_agent_pkg.sv
pci_init_if.sv
pci_bus_if.sv
pci_arbiter.sv
pci_initiator.sv
pci_target.sv
pci_monitor.sv
pci_subsys.sv
tb_clk_gen.sv
tb_pci_subsys.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing
TOP       = tb_pci_subsys
FILELIST  = sim.f

SRCS = $(shell cat $(FILELIST))
BIN  = obj_dir/V$(TOP)
LOG  = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
